// File: build.f
+incdir+rtl
rtl/cu_pkg.sv
rtl/instr_classifier.sv
rtl/microsequencer.sv
rtl/control_encoder.sv
rtl/control_unit.sv
tests/control_unit_asserts.sv
tests/control_unit_tb.sv

// File: rtl/control_encoder.sv
`timescale 1ns/1ps

module control_encoder (
	input  cu_pkg::state_t    state,
	output logic              rf_load_en,
	output logic              rf_clear_en,
	output logic              ir_ld,
	output logic              mar_ld,
	output logic              mdr_ld,
	output logic              pc_ld,
	output logic              npc_ld,
	output logic              fr_ld,
	output logic              r_w,
	output logic              mov,
	output cu_pkg::mem_type_t mem_type,
	output cu_pkg::mux2_t     mb,
	output cu_pkg::mux2_t     mnp,
	output cu_pkg::mux2_t     mp,
	output cu_pkg::mux2_t     msc,
	output logic              mm,
	output logic              mr,
	output logic              mop,
	output logic              msa,
	output cu_pkg::alu_op_t   alu_op
);

	always_comb begin
		rf_load_en  = 1'b0;
		rf_clear_en = 1'b0;
		ir_ld       = 1'b0;
		mar_ld      = 1'b0;
		mdr_ld      = 1'b0;
		pc_ld       = 1'b0;
		npc_ld      = 1'b0;
		fr_ld       = 1'b0;
		r_w         = 1'b0;
		mov         = 1'b0;
		mem_type    = 2'b00;
		mb          = 2'b00;
		mnp         = 2'b00;
		mp          = 2'b00;
		msc         = 2'b00;
		mm          = 1'b0;
		mr          = 1'b0;
		mop         = 1'b0;
		msa         = 1'b0;
		alu_op      = 6'b000000;
		case (state)
			cu_pkg::st_reset: begin
				rf_clear_en = 1'b1;
				pc_ld       = 1'b1;
				npc_ld      = 1'b1;
				mr          = 1'b1;
				mnp         = 2'b11;
			end
			// pc through the alu into mar, also the first step of a taken branch
			cu_pkg::st_fetch_addr, cu_pkg::st_branch_taken: begin
				mar_ld = 1'b1;
				mb     = 2'b10;
				mop    = 1'b1;
				mp     = 2'b11;
				alu_op = 6'b100001;
			end
			cu_pkg::st_fetch_pc: begin
				pc_ld    = 1'b1;
				r_w      = 1'b1;
				mov      = 1'b1;
				mem_type = 2'b10;
				mnp      = 2'b11;
				mp       = 2'b11;
			end
			cu_pkg::st_fetch_wait: begin
				ir_ld    = 1'b1;
				npc_ld   = 1'b1;
				r_w      = 1'b1;
				mov      = 1'b1;
				mem_type = 2'b10;
				mnp      = 2'b11;
			end
			cu_pkg::st_alu_reg: rf_load_en = 1'b1;
			cu_pkg::st_alu_imm: begin
				rf_load_en = 1'b1;
				mb         = 2'b01;
			end
			cu_pkg::st_alu_reg_cc: begin
				rf_load_en = 1'b1;
				fr_ld      = 1'b1;
			end
			cu_pkg::st_alu_imm_cc: begin
				rf_load_en = 1'b1;
				fr_ld      = 1'b1;
				mb         = 2'b01;
			end
			cu_pkg::st_sethi: begin
				rf_load_en = 1'b1;
				mb         = 2'b10;
				mop        = 1'b1;
			end
			cu_pkg::st_load_reg, cu_pkg::st_load_imm: begin
				mar_ld = 1'b1;
				r_w    = 1'b1;
				mop    = 1'b1;
				mb     = (state == cu_pkg::st_load_imm) ? 2'b01 : 2'b00;
			end
			cu_pkg::st_load_req: begin
				r_w = 1'b1;
				mov = 1'b1;
			end
			cu_pkg::st_load_wait: begin
				mdr_ld = 1'b1;
				r_w    = 1'b1;
				mov    = 1'b1;
			end
			cu_pkg::st_load_wb: begin
				rf_load_en = 1'b1;
				mb         = 2'b11;
				mop        = 1'b1;
				alu_op     = 6'b100001;
			end
			cu_pkg::st_store_reg, cu_pkg::st_store_imm: begin
				mar_ld = 1'b1;
				r_w    = 1'b1;
				mm     = 1'b1;
				mop    = 1'b1;
				mb     = (state == cu_pkg::st_store_imm) ? 2'b01 : 2'b00;
			end
			// store data from the register file into mdr
			cu_pkg::st_store_req: begin
				mdr_ld = 1'b1;
				mm     = 1'b1;
				mop    = 1'b1;
				msa    = 1'b1;
				alu_op = 6'b100000;
			end
			cu_pkg::st_store_wait: mov = 1'b1;
			cu_pkg::st_call_link, cu_pkg::st_jmpl_link: begin
				rf_load_en = 1'b1;
				mb         = 2'b10;
				mop        = 1'b1;
				alu_op     = 6'b100001;
				msc        = (state == cu_pkg::st_call_link) ? 2'b01 : 2'b00;
			end
			cu_pkg::st_call_jump, cu_pkg::st_jmpl_reg, cu_pkg::st_jmpl_imm: begin
				pc_ld  = 1'b1;
				npc_ld = 1'b1;
				mp     = 2'b11;
				mnp    = (state == cu_pkg::st_call_jump) ? 2'b10 : 2'b00;
				mb     = (state == cu_pkg::st_jmpl_imm) ? 2'b01 : 2'b00;
			end
			cu_pkg::st_branch_npc: begin
				npc_ld = 1'b1;
				mnp    = 2'b10;
				mp     = 2'b11;
			end
			cu_pkg::st_branch_fall: begin
				pc_ld  = 1'b1;
				npc_ld = 1'b1;
				mnp    = 2'b11;
				mp     = 2'b11;
			end
			// annulled slot is skipped
			cu_pkg::st_branch_annul: begin
				pc_ld  = 1'b1;
				npc_ld = 1'b1;
				mnp    = 2'b01;
				mp     = 2'b10;
			end
			default: ;
		endcase
	end

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps
`include "cu_config.svh"

module control_unit (
	input  logic              Clk,
	input  logic              Clr,
	input  cu_pkg::instr_t    instr,
	input  logic              bcond,
	input  logic              mem_done,
	output cu_pkg::state_t    state,
	output logic              rf_load_en,
	output logic              rf_clear_en,
	output logic              ir_ld,
	output logic              mar_ld,
	output logic              mdr_ld,
	output logic              pc_ld,
	output logic              npc_ld,
	output logic              fr_ld,
	output logic              r_w,
	output logic              mov,
	output cu_pkg::mem_type_t mem_type,
	output cu_pkg::mux2_t     mb,
	output cu_pkg::mux2_t     mnp,
	output cu_pkg::mux2_t     mp,
	output cu_pkg::mux2_t     msc,
	output logic              mm,
	output logic              mr,
	output logic              mop,
	output logic              msa,
	output cu_pkg::alu_op_t   alu_op
);

	cu_pkg::instr_class_t iclass;
	logic                 imm;

	instr_classifier classifier_i (
		.instr  (instr),
		.iclass (iclass),
		.imm    (imm)
	);

	microsequencer sequencer_i (
		.Clk      (Clk),
		.Clr      (Clr),
		.iclass   (iclass),
		.imm      (imm),
		.bcond    (bcond),
		.annul    (instr[`CU_ANNUL_BIT]),
		.mem_done (mem_done),
		.state    (state)
	);

	control_encoder encoder_i (
		.state       (state),
		.rf_load_en  (rf_load_en),
		.rf_clear_en (rf_clear_en),
		.ir_ld       (ir_ld),
		.mar_ld      (mar_ld),
		.mdr_ld      (mdr_ld),
		.pc_ld       (pc_ld),
		.npc_ld      (npc_ld),
		.fr_ld       (fr_ld),
		.r_w         (r_w),
		.mov         (mov),
		.mem_type    (mem_type),
		.mb          (mb),
		.mnp         (mnp),
		.mp          (mp),
		.msc         (msc),
		.mm          (mm),
		.mr          (mr),
		.mop         (mop),
		.msa         (msa),
		.alu_op      (alu_op)
	);

endmodule

// File: rtl/cu_config.svh
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// register widths
`define CU_INSTR_W 32
`define CU_STATE_W 7

// instruction word fields
`define CU_OP_HI 31
`define CU_OP_LO 30
`define CU_OP3_HI 24
`define CU_OP3_LO 19
`define CU_OP2_HI 24
`define CU_OP2_LO 22
`define CU_COND_HI 28
`define CU_COND_LO 25
`define CU_ANNUL_BIT 29
`define CU_IMM_BIT 13

`endif

// File: rtl/cu_pkg.sv
`include "cu_config.svh"

package cu_pkg;

	typedef logic [`CU_INSTR_W-1:0] instr_t;

	typedef logic [1:0] mux2_t;
	typedef logic [5:0] alu_op_t;
	typedef logic [1:0] mem_type_t;

	// codes follow the original microprogram numbering
	typedef enum logic [`CU_STATE_W-1:0] {
		st_reset        = 7'd0,
		st_fetch_addr   = 7'd1,
		st_fetch_pc     = 7'd2,
		st_fetch_wait   = 7'd3,
		st_decode       = 7'd4,
		st_alu_reg      = 7'd10,
		st_alu_imm      = 7'd11,
		st_alu_reg_cc   = 7'd12,
		st_alu_imm_cc   = 7'd13,
		st_sethi        = 7'd14,
		st_load_reg     = 7'd20,
		st_load_req     = 7'd21,
		st_load_wait    = 7'd22,
		st_load_wb      = 7'd23,
		st_store_reg    = 7'd25,
		st_store_req    = 7'd26,
		st_store_wait   = 7'd27,
		st_store_done   = 7'd28,
		st_load_imm     = 7'd30,
		st_store_imm    = 7'd35,
		st_call_link    = 7'd40,
		st_call_jump    = 7'd41,
		st_jmpl_link    = 7'd42,
		st_jmpl_reg     = 7'd43,
		st_jmpl_imm     = 7'd44,
		st_branch_taken = 7'd49,
		st_branch_npc   = 7'd50,
		st_branch_fall  = 7'd51,
		st_branch_annul = 7'd52
	} state_t;

	typedef enum logic [3:0] {
		ic_alu,
		ic_alu_cc,
		ic_sethi,
		ic_load,
		ic_store,
		ic_call,
		ic_jmpl,
		ic_branch,
		ic_other
	} instr_class_t;

endpackage

// File: rtl/instr_classifier.sv
`timescale 1ns/1ps
`include "cu_config.svh"

module instr_classifier (
	input  cu_pkg::instr_t       instr,
	output cu_pkg::instr_class_t iclass,
	output logic                 imm
);

	logic [1:0] op;
	logic [5:0] op3;
	logic [2:0] op2;
	logic       alu_op3;

	assign op  = instr[`CU_OP_HI:`CU_OP_LO];
	assign op3 = instr[`CU_OP3_HI:`CU_OP3_LO];
	assign op2 = instr[`CU_OP2_HI:`CU_OP2_LO];
	assign imm = instr[`CU_IMM_BIT];

	always_comb begin
		case (op3)
			// add, addx, sub, subx
			6'b000000, 6'b001000, 6'b000100, 6'b001100,
			6'b010000, 6'b011000, 6'b010100, 6'b011100,
			// and, andn, or, orn, xor, xnor
			6'b000001, 6'b000101, 6'b000010, 6'b000110, 6'b000011, 6'b000111,
			6'b010001, 6'b010101, 6'b010010, 6'b010110, 6'b010011, 6'b010111,
			// sll, srl, sra
			6'b100101, 6'b100110, 6'b100111:
				alu_op3 = 1'b1;
			default:
				alu_op3 = 1'b0;
		endcase
	end

	always_comb begin
		iclass = cu_pkg::ic_other;
		case (op)
			2'b00: begin
				if (op2 == 3'b100)
					iclass = cu_pkg::ic_sethi;
				else if (op2 == 3'b010)
					iclass = cu_pkg::ic_branch;
			end
			2'b01: iclass = cu_pkg::ic_call;
			2'b10: begin
				if (op3 == 6'b111000)
					iclass = cu_pkg::ic_jmpl;
				else if (alu_op3)
					iclass = op3[4] ? cu_pkg::ic_alu_cc : cu_pkg::ic_alu;
			end
			default: begin
				case (op3)
					// ld, ldub, lduh, ldd, ldsb, ldsh, ldstub
					6'b000000, 6'b000001, 6'b000010, 6'b000011,
					6'b001001, 6'b001010, 6'b001101:
						iclass = cu_pkg::ic_load;
					// st, stb, sth, std, swap
					6'b000100, 6'b000101, 6'b000110, 6'b000111, 6'b001111:
						iclass = cu_pkg::ic_store;
					default:
						iclass = cu_pkg::ic_other;
				endcase
			end
		endcase
	end

endmodule

// File: rtl/microsequencer.sv
`timescale 1ns/1ps

module microsequencer (
	input  logic                 Clk,
	input  logic                 Clr,
	input  cu_pkg::instr_class_t iclass,
	input  logic                 imm,
	input  logic                 bcond,
	input  logic                 annul,
	input  logic                 mem_done,
	output cu_pkg::state_t       state
);

	cu_pkg::state_t next_state;

	always_ff @(posedge Clk or negedge Clr) begin
		if (!Clr)
			state <= cu_pkg::st_reset;
		else
			state <= next_state;
	end

	always_comb begin
		// anything without its own rule goes back to fetch
		next_state = cu_pkg::st_fetch_addr;
		case (state)
			cu_pkg::st_fetch_addr: next_state = cu_pkg::st_fetch_pc;
			cu_pkg::st_fetch_pc:   next_state = cu_pkg::st_fetch_wait;
			cu_pkg::st_fetch_wait:
				next_state = mem_done ? cu_pkg::st_decode : cu_pkg::st_fetch_wait;
			cu_pkg::st_decode: begin
				case (iclass)
					cu_pkg::ic_alu:
						next_state = imm ? cu_pkg::st_alu_imm : cu_pkg::st_alu_reg;
					cu_pkg::ic_alu_cc:
						next_state = imm ? cu_pkg::st_alu_imm_cc : cu_pkg::st_alu_reg_cc;
					cu_pkg::ic_sethi: next_state = cu_pkg::st_sethi;
					cu_pkg::ic_load:
						next_state = imm ? cu_pkg::st_load_imm : cu_pkg::st_load_reg;
					cu_pkg::ic_store:
						next_state = imm ? cu_pkg::st_store_imm : cu_pkg::st_store_reg;
					cu_pkg::ic_call: next_state = cu_pkg::st_call_link;
					cu_pkg::ic_jmpl: next_state = cu_pkg::st_jmpl_link;
					cu_pkg::ic_branch: begin
						// always-taken branches arrive with bcond high
						if (bcond)
							next_state = cu_pkg::st_branch_taken;
						else if (annul)
							next_state = cu_pkg::st_branch_annul;
						else
							next_state = cu_pkg::st_branch_fall;
					end
					default: next_state = cu_pkg::st_fetch_addr;
				endcase
			end
			cu_pkg::st_load_reg, cu_pkg::st_load_imm: next_state = cu_pkg::st_load_req;
			cu_pkg::st_load_req: next_state = cu_pkg::st_load_wait;
			cu_pkg::st_load_wait:
				next_state = mem_done ? cu_pkg::st_load_wb : cu_pkg::st_load_wait;
			cu_pkg::st_store_reg, cu_pkg::st_store_imm: next_state = cu_pkg::st_store_req;
			cu_pkg::st_store_req: next_state = cu_pkg::st_store_wait;
			cu_pkg::st_store_wait:
				next_state = mem_done ? cu_pkg::st_store_done : cu_pkg::st_store_wait;
			cu_pkg::st_call_link: next_state = cu_pkg::st_call_jump;
			cu_pkg::st_jmpl_link:
				next_state = imm ? cu_pkg::st_jmpl_imm : cu_pkg::st_jmpl_reg;
			cu_pkg::st_branch_taken: next_state = cu_pkg::st_branch_npc;
			// target already sits in pc, so skip the address load
			cu_pkg::st_branch_npc: next_state = cu_pkg::st_fetch_pc;
			default: next_state = cu_pkg::st_fetch_addr;
		endcase
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module control_unit_tb -Mdir obj_dir -f build.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit "$status"
fi

./obj_dir/Vcontrol_unit_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0

// File: tests/control_unit_asserts.sv
`timescale 1ns/1ps

module control_unit_asserts (
	input logic           Clk,
	input logic           Clr,
	input logic           mem_done,
	input logic           mov,
	input logic           mar_ld,
	input logic           mdr_ld,
	input cu_pkg::state_t state
);

	// request held until the memory answers
	mov_held: assert property (@(posedge Clk) disable iff (!Clr)
		(mov && !mem_done) |=> mov)
		else $error("memory request dropped before mem_done");

	addr_data_excl: assert property (@(posedge Clk) disable iff (!Clr)
		!(mar_ld && mdr_ld))
		else $error("mar_ld and mdr_ld high in the same cycle");

	reset_state: assert property (@(posedge Clk)
		!Clr |-> (state == cu_pkg::st_reset))
		else $error("state left st_reset while Clr was low");

endmodule

bind control_unit control_unit_asserts asserts_i (
	.Clk      (Clk),
	.Clr      (Clr),
	.mem_done (mem_done),
	.mov      (mov),
	.mar_ld   (mar_ld),
	.mdr_ld   (mdr_ld),
	.state    (state)
);

// File: tests/control_unit_tb.sv
`timescale 1ns/1ps
`include "cu_config.svh"

module control_unit_tb;

	localparam int TRACE_MAX = 64;
	localparam int CYCLES_PER_ENTRY = 64;

	logic                 Clk = 1'b0;
	logic                 Clr;
	cu_pkg::instr_t       instr;
	logic                 bcond;
	logic                 mem_done;
	cu_pkg::state_t       state;
	logic                 rf_load_en;
	logic                 rf_clear_en;
	logic                 ir_ld;
	logic                 mar_ld;
	logic                 mdr_ld;
	logic                 pc_ld;
	logic                 npc_ld;
	logic                 fr_ld;
	logic                 r_w;
	logic                 mov;
	cu_pkg::mem_type_t    mem_type;
	cu_pkg::mux2_t        mb;
	cu_pkg::mux2_t        mnp;
	cu_pkg::mux2_t        mp;
	cu_pkg::mux2_t        msc;
	logic                 mm;
	logic                 mr;
	logic                 mop;
	logic                 msa;
	cu_pkg::alu_op_t      alu_op;

	// instr, bcond nibble, latency byte, expected state byte
	logic [51:0] trace_mem [0:TRACE_MAX-1];
	int          trace_len = 0;

	control_unit dut_i (
		.Clk         (Clk),
		.Clr         (Clr),
		.instr       (instr),
		.bcond       (bcond),
		.mem_done    (mem_done),
		.state       (state),
		.rf_load_en  (rf_load_en),
		.rf_clear_en (rf_clear_en),
		.ir_ld       (ir_ld),
		.mar_ld      (mar_ld),
		.mdr_ld      (mdr_ld),
		.pc_ld       (pc_ld),
		.npc_ld      (npc_ld),
		.fr_ld       (fr_ld),
		.r_w         (r_w),
		.mov         (mov),
		.mem_type    (mem_type),
		.mb          (mb),
		.mnp         (mnp),
		.mp          (mp),
		.msc         (msc),
		.mm          (mm),
		.mr          (mr),
		.mop         (mop),
		.msa         (msa),
		.alu_op      (alu_op)
	);

	always #2 Clk = ~Clk;

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_state(input cu_pkg::state_t got, input cu_pkg::state_t want);
		if (got !== want) begin
			$display("** Error at %0t: state = %s (%0d), expected %s (%0d)",
				$time, got.name(), got, want.name(), want);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_mux(input string name, input cu_pkg::mux2_t got,
		input cu_pkg::mux2_t want);
		if (got !== want) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_mem_type(input string name, input cu_pkg::mem_type_t got,
		input cu_pkg::mem_type_t want);
		if (got !== want) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_alu_op(input string name, input cu_pkg::alu_op_t got,
		input cu_pkg::alu_op_t want);
		if (got !== want) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	function automatic logic requests_memory(input cu_pkg::state_t s);
		return s inside {cu_pkg::st_fetch_pc, cu_pkg::st_fetch_wait, cu_pkg::st_load_req,
			cu_pkg::st_load_wait, cu_pkg::st_store_wait};
	endfunction

	function automatic logic writes_register(input cu_pkg::state_t s);
		return s inside {cu_pkg::st_alu_reg, cu_pkg::st_alu_imm, cu_pkg::st_alu_reg_cc,
			cu_pkg::st_alu_imm_cc, cu_pkg::st_sethi, cu_pkg::st_load_wb,
			cu_pkg::st_call_link, cu_pkg::st_jmpl_link};
	endfunction

	function automatic logic updates_flags(input cu_pkg::state_t s);
		return s inside {cu_pkg::st_alu_reg_cc, cu_pkg::st_alu_imm_cc};
	endfunction

	function automatic logic loads_address(input cu_pkg::state_t s);
		return s inside {cu_pkg::st_fetch_addr, cu_pkg::st_load_reg, cu_pkg::st_load_imm,
			cu_pkg::st_store_reg, cu_pkg::st_store_imm};
	endfunction

	// state plus the control bits that the state fixes
	task automatic check_step(input cu_pkg::state_t want);
		check_state(state, want);
		check_bit("mov", mov, requests_memory(want));
		check_bit("rf_load_en", rf_load_en, writes_register(want));
		check_bit("fr_ld", fr_ld, updates_flags(want));
		if (loads_address(want))
			check_bit("mar_ld", mar_ld, 1'b1);
		if (want == cu_pkg::st_fetch_wait)
			check_bit("ir_ld", ir_ld, 1'b1);
		if (want == cu_pkg::st_load_wait || want == cu_pkg::st_store_req)
			check_bit("mdr_ld", mdr_ld, 1'b1);
	endtask

	task automatic advance_cycle();
		@(posedge Clk);
		@(negedge Clk);
	endtask

	// called just after the edge that enters the wait state
	task automatic serve_memory(input int latency, input cu_pkg::state_t wait_st);
		int                k;
		cu_pkg::mux2_t     held_mb;
		cu_pkg::mux2_t     held_mnp;
		cu_pkg::mux2_t     held_mp;
		cu_pkg::mux2_t     held_msc;
		cu_pkg::mem_type_t held_mem_type;
		cu_pkg::alu_op_t   held_alu_op;
		logic              held_rf_clear_en;
		logic              held_ir_ld;
		logic              held_mar_ld;
		logic              held_mdr_ld;
		logic              held_pc_ld;
		logic              held_npc_ld;
		logic              held_r_w;
		logic              held_mm;
		logic              held_mr;
		logic              held_mop;
		logic              held_msa;
		if (latency < 1) begin
			$display("memory latency in the trace must be at least one cycle");
			abort_run();
		end else begin
			for (k = 1; k <= latency; k++) begin
				// done is sampled on the edge ending the last wait cycle
				if (k == latency)
					mem_done <= 1'b1;
				@(negedge Clk);
				check_step(wait_st);
				if (k == 1) begin
					held_mb          = mb;
					held_mnp         = mnp;
					held_mp          = mp;
					held_msc         = msc;
					held_mem_type    = mem_type;
					held_alu_op      = alu_op;
					held_rf_clear_en = rf_clear_en;
					held_ir_ld       = ir_ld;
					held_mar_ld      = mar_ld;
					held_mdr_ld      = mdr_ld;
					held_pc_ld       = pc_ld;
					held_npc_ld      = npc_ld;
					held_r_w         = r_w;
					held_mm          = mm;
					held_mr          = mr;
					held_mop         = mop;
					held_msa         = msa;
				end else begin
					check_mux("mb", mb, held_mb);
					check_mux("mnp", mnp, held_mnp);
					check_mux("mp", mp, held_mp);
					check_mux("msc", msc, held_msc);
					check_mem_type("mem_type", mem_type, held_mem_type);
					check_alu_op("alu_op", alu_op, held_alu_op);
					check_bit("rf_clear_en", rf_clear_en, held_rf_clear_en);
					check_bit("ir_ld", ir_ld, held_ir_ld);
					check_bit("mar_ld", mar_ld, held_mar_ld);
					check_bit("mdr_ld", mdr_ld, held_mdr_ld);
					check_bit("pc_ld", pc_ld, held_pc_ld);
					check_bit("npc_ld", npc_ld, held_npc_ld);
					check_bit("r_w", r_w, held_r_w);
					check_bit("mm", mm, held_mm);
					check_bit("mr", mr, held_mr);
					check_bit("mop", mop, held_mop);
					check_bit("msa", msa, held_msa);
				end
				@(posedge Clk);
			end
			mem_done <= 1'b0;
		end
	endtask

	task automatic run_entry(input logic [51:0] entry, inout logic at_pc);
		cu_pkg::instr_t word;
		logic           taken;
		int             latency;
		cu_pkg::state_t exp_state;
		word      = entry[51:20];
		taken     = entry[16];
		latency   = {24'd0, entry[15:8]};
		exp_state = cu_pkg::state_t'(entry[6:0]);
		if (!at_pc) begin
			check_step(cu_pkg::st_fetch_addr);
			advance_cycle();
		end
		check_step(cu_pkg::st_fetch_pc);
		@(posedge Clk);
		instr <= word;
		bcond <= taken;
		serve_memory($urandom_range(3, 0) + 1, cu_pkg::st_fetch_wait);
		@(negedge Clk);
		check_step(cu_pkg::st_decode);
		advance_cycle();
		check_step(exp_state);
		at_pc = 1'b0;
		case (exp_state)
			cu_pkg::st_load_reg, cu_pkg::st_load_imm: begin
				advance_cycle();
				check_step(cu_pkg::st_load_req);
				@(posedge Clk);
				serve_memory(latency, cu_pkg::st_load_wait);
				@(negedge Clk);
				check_step(cu_pkg::st_load_wb);
				advance_cycle();
			end
			cu_pkg::st_store_reg, cu_pkg::st_store_imm: begin
				advance_cycle();
				check_step(cu_pkg::st_store_req);
				@(posedge Clk);
				serve_memory(latency, cu_pkg::st_store_wait);
				@(negedge Clk);
				check_step(cu_pkg::st_store_done);
				advance_cycle();
			end
			cu_pkg::st_call_link: begin
				advance_cycle();
				check_step(cu_pkg::st_call_jump);
				advance_cycle();
			end
			cu_pkg::st_jmpl_link: begin
				advance_cycle();
				check_step(word[`CU_IMM_BIT] ? cu_pkg::st_jmpl_imm : cu_pkg::st_jmpl_reg);
				advance_cycle();
			end
			cu_pkg::st_branch_taken: begin
				advance_cycle();
				check_step(cu_pkg::st_branch_npc);
				advance_cycle();
				at_pc = 1'b1;
			end
			// unknown opcode is already back at fetch
			cu_pkg::st_fetch_addr: ;
			default: advance_cycle();
		endcase
	endtask

	initial begin : stimulus
		int   i;
		logic at_pc;
		Clr      <= 1'b0;
		instr    <= '0;
		bcond    <= 1'b0;
		mem_done <= 1'b0;
		void'($urandom(32'hf889_d625));
		for (i = 0; i < TRACE_MAX; i++)
			trace_mem[i] = '1;
		$readmemh("tests/control_unit_trace.txt", trace_mem);
		while (trace_len < TRACE_MAX && trace_mem[trace_len] != '1)
			trace_len++;
		if (trace_len == 0) begin
			$display("trace file holds no entries");
			abort_run();
		end
		repeat (4) begin
			@(negedge Clk);
			check_state(state, cu_pkg::st_reset);
			check_bit("rf_clear_en", rf_clear_en, 1'b1);
			check_bit("pc_ld", pc_ld, 1'b1);
			check_bit("npc_ld", npc_ld, 1'b1);
			check_bit("mr", mr, 1'b1);
			check_bit("mov", mov, 1'b0);
			check_bit("ir_ld", ir_ld, 1'b0);
			check_bit("fr_ld", fr_ld, 1'b0);
			check_bit("mar_ld", mar_ld, 1'b0);
			check_bit("mdr_ld", mdr_ld, 1'b0);
		end
		@(posedge Clk);
		Clr <= 1'b1;
		@(negedge Clk);
		check_state(state, cu_pkg::st_reset);
		advance_cycle();
		at_pc = 1'b0;
		for (i = 0; i < trace_len; i++)
			run_entry(trace_mem[i], at_pc);
		$display(">>> PASS");
		$finish;
	end

	initial begin : watchdog
		wait (trace_len > 0);
		repeat (trace_len * CYCLES_PER_ENTRY) @(posedge Clk);
		$display("watchdog expired before the trace was finished");
		abort_run();
	end

endmodule

// File: tests/control_unit_trace.txt
// columns: instruction word, bcond, memory latency in cycles,
// state expected right after st_decode (all hex)
82008003_0_00_0a
8200a005_0_00_0b
82808003_0_00_0c
8290a0ff_0_00_0d
8328a004_0_00_0b
82188003_0_00_0a
82a0a001_0_00_0d
83388003_0_00_0a
03012345_0_00_0e
c2008003_0_03_14
c208a010_0_01_1e
c250a002_0_05_1e
c2208003_0_02_19
c228a008_0_04_23
40000010_0_00_28
9fc08003_0_00_2a
81c0a008_0_00_2a
10800004_1_00_31
82008003_0_00_0a
12800004_0_00_33
22800004_0_00_34
32800008_1_00_31
81480000_0_00_01
00000000_0_00_01
c2008003_0_01_14
